//--- src/bridge_pkg.sv
package bridge_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus widths
	//////////////////////////////////////////////////////////////////////

	// Byte address from the CPU data side
	typedef logic [31:0] addr_t;
	// Data word, no sub-word access
	typedef logic [31:0] word_t;
	// Hardware interrupt vector, {ext[3:0], timer1, timer0}
	typedef logic [5:0] hwirq_t;
	// External interrupt lines
	typedef logic [3:0] ext_irq_t;
	// Word index inside a timer window
	typedef logic [1:0] reg_off_t;

	//////////////////////////////////////////////////////////////////////
	// Address map
	//////////////////////////////////////////////////////////////////////

	localparam addr_t TIMER0_BASE = 32'h0000_7f00;
	localparam addr_t TIMER1_BASE = 32'h0000_7f10;
	// Three word registers per timer
	localparam addr_t TIMER_SPAN = 32'd12;

	// Register indices, byte offset / 4
	localparam reg_off_t REG_CTRL = 2'd0;
	localparam reg_off_t REG_PRESET = 2'd1;
	localparam reg_off_t REG_COUNT = 2'd2;

	// CTRL bit positions
	localparam int CTRL_EN_BIT = 0;
	localparam int CTRL_MODE_LSB = 1;
	localparam int CTRL_IM_BIT = 3;

	//////////////////////////////////////////////////////////////////////
	// Timer encodings
	//////////////////////////////////////////////////////////////////////

	// Codes 2 and 3 behave as one-shot
	typedef enum logic [1:0] {
		MODE_ONESHOT = 2'd0,
		MODE_RELOAD = 2'd1
	} timer_mode_e;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		CNT,
		INT
	} timer_state_e;

endpackage

//--- src/timer_reg_if.sv
`timescale 1ns/10ps

// One timer's register port
interface timer_reg_if;

	// Bridge side
	logic sel;
	bridge_pkg::reg_off_t off;
	logic we;
	bridge_pkg::word_t wdata;

	// Timer side
	bridge_pkg::word_t rdata;
	logic irq;

	modport bridge (
		output sel,
		output off,
		output we,
		output wdata,
		input rdata,
		input irq
	);

	modport tmr (
		input sel,
		input off,
		input we,
		input wdata,
		output rdata,
		output irq
	);

endinterface

//--- src/timer.sv
`timescale 1ns/10ps

module timer (
	input logic clk,
	input logic reset,
	timer_reg_if.tmr regs
);

	//////////////////////////////////////////////////////////////////////
	// Registers and decode
	//////////////////////////////////////////////////////////////////////

	// CTRL holds {im, mode[1:0], en}
	logic [3:0] ctrl;
	logic [3:0] ctrl_next;
	bridge_pkg::word_t preset;
	bridge_pkg::word_t count;
	// One-shot interrupt latch
	logic pending;

	bridge_pkg::timer_state_e state;
	bridge_pkg::timer_state_e state_next;

	logic wr_ctrl;
	logic wr_preset;
	logic en_next;
	logic mask;
	logic reload;
	logic enter_int;
	bridge_pkg::timer_mode_e mode;

	// Writes need sel and we together
	assign wr_ctrl = regs.sel && regs.we && (regs.off == bridge_pkg::REG_CTRL);
	assign wr_preset = regs.sel && regs.we && (regs.off == bridge_pkg::REG_PRESET);
	// COUNT is read-only, no write strobe

	assign mode = bridge_pkg::timer_mode_e'(ctrl[bridge_pkg::CTRL_MODE_LSB +: 2]);
	assign mask = ctrl[bridge_pkg::CTRL_IM_BIT];
	// Anything but reload counts as one-shot
	assign reload = (mode == bridge_pkg::MODE_RELOAD);

	// CTRL next value, a bus write wins over auto-clear
	always_comb begin
		ctrl_next = ctrl;
		if (wr_ctrl)
			ctrl_next = regs.wdata[3:0];
		else if (state == bridge_pkg::INT && !reload)
			ctrl_next[bridge_pkg::CTRL_EN_BIT] = 1'b0;
	end

	// Enable as seen after this edge
	assign en_next = ctrl_next[bridge_pkg::CTRL_EN_BIT];

	//////////////////////////////////////////////////////////////////////
	// Count FSM
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			bridge_pkg::IDLE: begin
				// Also re-arms a reload timer
				if (en_next)
					state_next = bridge_pkg::LOAD;
			end
			bridge_pkg::LOAD: begin
				state_next = en_next ? bridge_pkg::CNT : bridge_pkg::IDLE;
			end
			bridge_pkg::CNT: begin
				if (!en_next)
					state_next = bridge_pkg::IDLE;
				else if (count == '0)
					state_next = bridge_pkg::INT;
			end
			bridge_pkg::INT: begin
				state_next = bridge_pkg::IDLE;
			end
			default: begin
				state_next = bridge_pkg::IDLE;
			end
		endcase
	end

	assign enter_int = (state == bridge_pkg::CNT) && (state_next == bridge_pkg::INT);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= bridge_pkg::IDLE;
			ctrl <= '0;
			preset <= '0;
			count <= '0;
			pending <= 1'b0;
		end else begin
			state <= state_next;
			ctrl <= ctrl_next;
			if (wr_preset)
				preset <= regs.wdata;
			// Disable freezes COUNT where it is
			if (state == bridge_pkg::LOAD && en_next)
				count <= preset;
			else if (state == bridge_pkg::CNT && en_next && count != '0)
				count <= count - 1'b1;
			// Any CTRL write acknowledges
			if (wr_ctrl)
				pending <= 1'b0;
			else if (enter_int && mask && !reload)
				pending <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read port and interrupt
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (regs.off)
			bridge_pkg::REG_CTRL:   regs.rdata = {28'd0, ctrl};
			bridge_pkg::REG_PRESET: regs.rdata = preset;
			bridge_pkg::REG_COUNT:  regs.rdata = count;
			default:                regs.rdata = '0;
		endcase
	end

	// Reload pulses in INT, one-shot holds until acked
	assign regs.irq = pending || (state == bridge_pkg::INT && reload && mask);

	// Masked timer never interrupts
	irq_masked_a: assert property (@(posedge clk) disable iff (reset)
		regs.irq |-> mask);

	// IDLE holds COUNT across the edge
	count_idle_a: assert property (@(posedge clk) disable iff (reset)
		state == bridge_pkg::IDLE |=> $stable(count));

endmodule

//--- src/bridge.sv
`timescale 1ns/10ps

module bridge (
	input bridge_pkg::addr_t addr,
	input logic write_enable,
	input bridge_pkg::word_t write_data,
	output bridge_pkg::word_t read_result,
	input bridge_pkg::ext_irq_t ext_irq,
	output bridge_pkg::hwirq_t hwirq,
	timer_reg_if.bridge t0,
	timer_reg_if.bridge t1
);

	//////////////////////////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////////////////////////

	logic aligned;
	// Byte offset into each window
	bridge_pkg::addr_t off0;
	bridge_pkg::addr_t off1;
	logic hit0;
	logic hit1;

	// Word access only
	assign aligned = (addr[1:0] == 2'b00);

	assign off0 = addr - bridge_pkg::TIMER0_BASE;
	assign off1 = addr - bridge_pkg::TIMER1_BASE;

	// Inside window and below offset 12
	assign hit0 = aligned && (addr >= bridge_pkg::TIMER0_BASE) &&
		(off0 < bridge_pkg::TIMER_SPAN);
	assign hit1 = aligned && (addr >= bridge_pkg::TIMER1_BASE) &&
		(off1 < bridge_pkg::TIMER_SPAN);

	//////////////////////////////////////////////////////////////////////
	// Write steering
	//////////////////////////////////////////////////////////////////////

	assign t0.sel = hit0;
	assign t0.off = off0[3:2];
	// Timer qualifies we with its own sel
	assign t0.we = write_enable;
	assign t0.wdata = write_data;

	assign t1.sel = hit1;
	assign t1.off = off1[3:2];
	assign t1.we = write_enable;
	assign t1.wdata = write_data;

	//////////////////////////////////////////////////////////////////////
	// Read mux and interrupts
	//////////////////////////////////////////////////////////////////////

	// Same-cycle read, invalid address reads 0
	always_comb begin
		if (hit0)
			read_result = t0.rdata;
		else if (hit1)
			read_result = t1.rdata;
		else
			read_result = '0;
	end

	// Bit 0 timer 0, bit 1 timer 1, externals above
	assign hwirq = {ext_irq, t1.irq, t0.irq};

	// Windows in the address map must not overlap
	always_comb begin
		sel_excl_a: assert final (!(t0.sel && t1.sel))
			else $error("both timer windows decoded at addr %h", addr);
	end

endmodule

//--- src/bridge_top.sv
`timescale 1ns/10ps

module bridge_top (
	input logic clk,
	input logic reset,
	input bridge_pkg::addr_t addr,
	input logic write_enable,
	input bridge_pkg::word_t write_data,
	output bridge_pkg::word_t read_result,
	output bridge_pkg::hwirq_t hwirq,
	input bridge_pkg::ext_irq_t ext_irq
);

	//////////////////////////////////////////////////////////////////////
	// Register ports, one per timer
	//////////////////////////////////////////////////////////////////////

	timer_reg_if t0_if ();
	timer_reg_if t1_if ();

	// Decoder and read mux
	bridge bridge_i (
		.addr         (addr),
		.write_enable (write_enable),
		.write_data   (write_data),
		.read_result  (read_result),
		.ext_irq      (ext_irq),
		.hwirq        (hwirq),
		.t0           (t0_if.bridge),
		.t1           (t1_if.bridge)
	);

	// Timer 0 at 0x7f00
	timer timer0_i (
		.clk   (clk),
		.reset (reset),
		.regs  (t0_if.tmr)
	);

	// Timer 1 at 0x7f10
	timer timer1_i (
		.clk   (clk),
		.reset (reset),
		.regs  (t1_if.tmr)
	);

endmodule

//--- tests/bridge_clk_gen.sv
`timescale 1ns/10ps

module bridge_clk_gen (
	output logic clk,
	output logic reset
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset held over the first 4 rising edges
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

//--- tests/bridge_tb.sv
`timescale 1ns/10ps

module bridge_tb;

	//////////////////////////////////////////////////////////////////////
	// DUT signals and step table
	//////////////////////////////////////////////////////////////////////

	logic clk;
	logic reset;
	bridge_pkg::addr_t addr;
	logic write_enable;
	bridge_pkg::word_t write_data;
	bridge_pkg::word_t read_result;
	bridge_pkg::hwirq_t hwirq;
	bridge_pkg::ext_irq_t ext_irq;

	// Step kinds in the vector file
	localparam int STEP_WRITE = 0;
	localparam int STEP_READ = 1;
	localparam int STEP_IDLE = 2;

	int kind_q[$];
	bridge_pkg::addr_t addr_q[$];
	bridge_pkg::word_t data_q[$];
	bridge_pkg::word_t rd_exp_q[$];
	// Timer bits of hwirq only
	logic [1:0] irq_exp_q[$];

	int seed;
	// Clock cycles the table needs
	int run_cycles;
	// ext_irq of the current step
	bridge_pkg::ext_irq_t ext_val;

	bridge_clk_gen clk_gen_i (
		.clk   (clk),
		.reset (reset)
	);

	bridge_top dut_i (
		.clk          (clk),
		.reset        (reset),
		.addr         (addr),
		.write_enable (write_enable),
		.write_data   (write_data),
		.read_result  (read_result),
		.hwirq        (hwirq),
		.ext_irq      (ext_irq)
	);

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	task automatic stop_on_failure(input string why);
		$display("Simulation finished: FAIL");
		$fatal(1, "%s", why);
	endtask

	task automatic check_word(input int step, input bridge_pkg::word_t got,
		input bridge_pkg::word_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t: step %0d read_result 0x%08h, expected 0x%08h",
				$time, step, got, exp);
			stop_on_failure("read_result mismatch");
		end
	endtask

	task automatic check_irq(input int step, input bridge_pkg::hwirq_t got,
		input bridge_pkg::hwirq_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t: step %0d hwirq %b, expected %b",
				$time, step, got, exp);
			stop_on_failure("hwirq mismatch");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Vector file and stimulus
	//////////////////////////////////////////////////////////////////////

	// Columns are kind, addr, data, expected read, expected hwirq[1:0]
	task automatic load_steps();
		int fd;
		int k;
		int n;
		int cycles;
		string line;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] r;
		logic [31:0] i;
		cycles = 0;
		fd = $fopen("tests/bridge_tests.txt", "r");
		if (fd == 0) begin
			stop_on_failure("cannot open tests/bridge_tests.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				// Comments and blank lines
				if (line.len() < 2 || line[0] == "#")
					continue;
				n = $sscanf(line, "%h %h %h %h %h", k, a, d, r, i);
				if (n != 5) begin
					stop_on_failure({"malformed line in vector file: ", line});
				end else begin
					kind_q.push_back(k);
					addr_q.push_back(a);
					data_q.push_back(d);
					rd_exp_q.push_back(r);
					irq_exp_q.push_back(i[1:0]);
					// Idle steps last data cycles
					cycles += (k == STEP_IDLE) ? int'(d) : 1;
				end
			end
			$fclose(fd);
			// Published once the whole table is in
			run_cycles = cycles;
		end
	endtask

	// New ext_irq every cycle
	task automatic drive_inputs(input logic we, input bridge_pkg::addr_t a,
		input bridge_pkg::word_t d);
		logic [31:0] r;
		r = $random(seed);
		ext_val = r[3:0];
		addr <= a;
		write_enable <= we;
		write_data <= d;
		ext_irq <= ext_val;
	endtask

	// Starts and ends on a rising edge
	task automatic run_step(input int s);
		if (kind_q[s] == STEP_IDLE) begin
			repeat (data_q[s]) begin
				drive_inputs(1'b0, '0, '0);
				@(posedge clk);
			end
		end else begin
			drive_inputs(kind_q[s] == STEP_WRITE, addr_q[s], data_q[s]);
			// Outputs settled by the falling edge
			@(negedge clk);
			if (kind_q[s] == STEP_READ)
				check_word(s, read_result, rd_exp_q[s]);
			check_irq(s, hwirq, {ext_val, irq_exp_q[s]});
			@(posedge clk);
		end
	endtask

	initial begin : stimulus
		addr <= '0;
		write_enable <= 1'b0;
		write_data <= '0;
		ext_irq <= '0;
		seed = 32'hf36e;
		load_steps();
		if (kind_q.size() == 0) begin
			stop_on_failure("vector file holds no steps");
		end else begin
			wait (reset == 1'b0);
			@(posedge clk);
			foreach (kind_q[s])
				run_step(s);
			$display("Simulation finished: PASS");
			$finish;
		end
	end

	// 20 ns per cycle plus reset and slack
	initial begin : watchdog
		wait (run_cycles > 0);
		#((run_cycles + 4 + 20) * 20);
		stop_on_failure("watchdog expired, tests did not complete in time");
	end

endmodule

//--- tests/bridge_tests.txt
# kind addr data exp_read exp_irq, all hex, exp_irq is hwirq[1:0]
# kind 0 write, 1 read, 2 idle for data cycles
1 00007f00 0 00000000 0
1 00007f08 0 00000000 0
1 00007f18 0 00000000 0
1 00007f02 0 00000000 0
1 00007f1c 0 00000000 0
1 00007f0c 0 00000000 0
0 00007f04 00001234 0 0
1 00007f04 0 00001234 0
0 00007f08 0000ffff 0 0
0 00007f06 0000dead 0 0
0 00007f1c 0000beef 0 0
1 00007f04 0 00001234 0
1 00007f08 0 00000000 0
1 00007f14 0 00000000 0
0 00007f04 00000005 0 0
0 00007f00 00000009 0 0
2 00000000 1 0 0
1 00007f08 0 00000005 0
1 00007f08 0 00000004 0
1 00007f08 0 00000003 0
1 00007f08 0 00000002 0
1 00007f08 0 00000001 0
1 00007f08 0 00000000 0
1 00007f08 0 00000000 1
1 00007f00 0 00000008 1
0 00007f00 00000000 0 1
1 00007f00 0 00000000 0
0 00007f00 0000000b 0 0
2 00000000 7 0 0
1 00007f08 0 00000000 1
1 00007f08 0 00000000 0
2 00000000 1 0 0
1 00007f08 0 00000005 0
2 00000000 5 0 0
1 00007f08 0 00000000 1
1 00007f08 0 00000000 0
0 00007f00 00000000 0 0
0 00007f00 00000009 0 0
2 00000000 2 0 0
0 00007f00 00000008 0 0
1 00007f08 0 00000004 0
2 00000000 4 0 0
1 00007f08 0 00000004 0
0 00007f14 00000003 0 0
0 00007f10 00000009 0 0
2 00000000 4 0 0
1 00007f18 0 00000000 0
1 00007f18 0 00000000 2
1 00007f08 0 00000004 2
0 00007f10 00000000 0 2
1 00007f10 0 00000000 0

//--- vlog.f
src/bridge_pkg.sv
src/timer_reg_if.sv
src/timer.sv
src/bridge.sv
src/bridge_top.sv
tests/bridge_clk_gen.sv
tests/bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module bridge_tb -f vlog.f -o bridge_sim &&
	./obj_dir/bridge_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
	echo "run_sim: simulation passed" ||
	{ echo "run_sim: simulation failed"; exit 1; }
